/* wb_pkg.sv */
// --------------------------------------------------
// wb_pkg
// widths, EFLAGS bit positions and the flag mask
// type shared by the writeback stage
// --------------------------------------------------

`default_nettype none

package wb_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int word_w = 32;
	// one mask bit per arithmetic or status flag
	localparam int mask_w = 7;

	// results, operands and the flags word
	typedef logic [word_w-1:0] word_t;

	// affected-flag mask
	// bit 6 OF, 5 DF, 4 SF, 3 ZF, 2 AF, 1 PF, 0 CF
	typedef logic [mask_w-1:0] flag_mask_t;

	// --------------------------------------------------
	// flag positions in the 32-bit EFLAGS word
	// --------------------------------------------------
	localparam int flag_pos_of = 11;
	localparam int flag_pos_df = 10;
	localparam int flag_pos_sf = 7;
	localparam int flag_pos_zf = 6;
	localparam int flag_pos_af = 4;
	localparam int flag_pos_pf = 2;
	localparam int flag_pos_cf = 0;

	// all flags clear out of reset
	localparam word_t flags_reset_val = '0;

endpackage

`default_nettype wire

/* wb_uop_if.sv */
// --------------------------------------------------
// wb_uop_if
// decoded control bits of the micro-op in writeback
// --------------------------------------------------

`default_nettype none

interface wb_uop_if;
	import wb_pkg::*;

	// qualifies everything below
	logic valid;

	// base load bits from decode / execute
	logic ld_eip;
	logic ld_gpr1;
	logic ld_gpr2;
	logic ld_gpr3;
	logic ld_seg;
	logic ld_mm;
	logic dcache_write;
	logic ld_flags;

	// conditional forms
	logic is_jne;
	logic is_jnbe;
	logic is_cmovc;

	// halt and string-op control
	logic is_halt;
	logic is_cmps_first;
	logic is_cmps_second;
	logic repne;

	// which flags this uop writes
	flag_mask_t flags_affected;

	// top level drives the whole bundle
	modport src (
		output valid, ld_eip, ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm,
		output dcache_write, ld_flags, is_jne, is_jnbe, is_cmovc,
		output is_halt, is_cmps_first, is_cmps_second, repne, flags_affected
	);

	// commit control, no use for the flag mask
	modport ctl (
		input valid, ld_eip, ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm,
		input dcache_write, ld_flags, is_jne, is_jnbe, is_cmovc,
		input is_halt, is_cmps_first, is_cmps_second, repne
	);

	// flags register and cmps operand select
	modport data (
		input valid, ld_flags, flags_affected, is_cmps_first, is_cmps_second
	);

endinterface

`default_nettype wire

/* wb_flags.sv */
// --------------------------------------------------
// wb_flags
// committed EFLAGS register, masked update of the
// seven arithmetic and status flags
// --------------------------------------------------

`default_nettype none

module wb_flags (
	input  logic          clk,
	input  logic          rst,
	wb_uop_if.data        uop,
	input  logic          ld_flags_v,
	input  wb_pkg::word_t wb_flags_in,
	output wb_pkg::word_t current_flags
);
	import wb_pkg::*;

	word_t flags_next;
	// bits outside the seven writable flags
	logic [24:0] reserved_bits;

	// --------------------------------------------------
	// next value, one mux per flag
	// --------------------------------------------------
	always_comb
	begin
		// start from the held value
		flags_next = current_flags;
		if (uop.flags_affected[6])
			flags_next[flag_pos_of] = wb_flags_in[flag_pos_of];
		if (uop.flags_affected[5])
			flags_next[flag_pos_df] = wb_flags_in[flag_pos_df];
		if (uop.flags_affected[4])
			flags_next[flag_pos_sf] = wb_flags_in[flag_pos_sf];
		if (uop.flags_affected[3])
			flags_next[flag_pos_zf] = wb_flags_in[flag_pos_zf];
		if (uop.flags_affected[2])
			flags_next[flag_pos_af] = wb_flags_in[flag_pos_af];
		if (uop.flags_affected[1])
			flags_next[flag_pos_pf] = wb_flags_in[flag_pos_pf];
		if (uop.flags_affected[0])
			flags_next[flag_pos_cf] = wb_flags_in[flag_pos_cf];
	end

	// register, loads only on a validated flag write
	always_ff @(posedge clk)
	begin
		if (rst)
			current_flags <= flags_reset_val;
		else if (ld_flags_v)
			current_flags <= flags_next;
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	assign reserved_bits = {current_flags[31:12], current_flags[9:8],
		current_flags[5], current_flags[3], current_flags[1]};

	// reserved and upper bits stay at their reset value
	a_reserved_hold: assert property (@(posedge clk) disable iff (rst)
		reserved_bits == $past(reserved_bits));

endmodule

`default_nettype wire

/* wb_cmps_select.sv */
// --------------------------------------------------
// wb_cmps_select
// holds the first CMPS result, picks the first
// data operand for the second CMPS uop
// --------------------------------------------------

`default_nettype none

module wb_cmps_select (
	input  logic          clk,
	input  logic          rst,
	wb_uop_if.data        uop,
	input  wb_pkg::word_t result_a,
	output wb_pkg::word_t data1
);
	import wb_pkg::*;

	// pointer left behind by the first cmps uop
	word_t cmps_first_ptr;

	// capture on a valid first uop
	always_ff @(posedge clk)
	begin
		if (rst)
			cmps_first_ptr <= '0;
		else if (uop.valid && uop.is_cmps_first)
			cmps_first_ptr <= result_a;
	end

	// second uop reuses the stored pointer
	// any other uop passes result_a through
	always_comb
	begin
		if (uop.is_cmps_second)
			data1 = cmps_first_ptr;
		else
			data1 = result_a;
	end

	// a uop is one half of the pair, never both
	a_cmps_exclusive: assert property (@(posedge clk) disable iff (rst)
		uop.valid |-> !(uop.is_cmps_first && uop.is_cmps_second));

endmodule

`default_nettype wire

/* wb_commit_ctl.sv */
// --------------------------------------------------
// wb_commit_ctl
// resolves conditional loads from committed CF/ZF,
// validates write enables, halt and REPNE stop
// --------------------------------------------------

`default_nettype none

module wb_commit_ctl (
	wb_uop_if.ctl         uop,
	input  wb_pkg::word_t current_flags,
	input  wb_pkg::word_t result_c,
	output logic          v_ld_eip,
	output logic          v_ld_gpr1,
	output logic          v_ld_gpr2,
	output logic          v_ld_gpr3,
	output logic          v_ld_seg,
	output logic          v_ld_mm,
	output logic          v_dcache_write,
	output logic          ld_flags_v,
	output logic          halt,
	output logic          repne_terminate
);
	import wb_pkg::*;

	// committed flags, before this uop writes them
	logic cf;
	logic zf;
	// load bits after condition resolution
	logic ld_eip_res;
	logic ld_gpr1_res;
	// remaining repne count reached zero
	logic count_zero;

	assign cf = current_flags[flag_pos_cf];
	assign zf = current_flags[flag_pos_zf];

	// --------------------------------------------------
	// conditional forms
	// --------------------------------------------------
	always_comb
	begin
		// jnbe checked first, jne second
		if (uop.is_jnbe)
			ld_eip_res = !cf && !zf;
		else if (uop.is_jne)
			ld_eip_res = !zf;
		else
			ld_eip_res = uop.ld_eip;
	end

	// cmovc moves only on carry
	assign ld_gpr1_res = uop.is_cmovc ? cf : uop.ld_gpr1;

	// --------------------------------------------------
	// validated enables
	// --------------------------------------------------
	assign v_ld_eip       = uop.valid && ld_eip_res;
	assign v_ld_gpr1      = uop.valid && ld_gpr1_res;
	assign v_ld_gpr2      = uop.valid && uop.ld_gpr2;
	assign v_ld_gpr3      = uop.valid && uop.ld_gpr3;
	assign v_ld_seg       = uop.valid && uop.ld_seg;
	assign v_ld_mm        = uop.valid && uop.ld_mm;
	assign v_dcache_write = uop.valid && uop.dcache_write;
	assign ld_flags_v     = uop.valid && uop.ld_flags;

	// --------------------------------------------------
	// halt and repne
	// --------------------------------------------------
	assign halt = uop.valid && uop.is_halt;

	assign count_zero = (result_c == '0);

	// stop on a match (ZF) or an exhausted count
	// only the second cmps uop of a repne loop decides
	assign repne_terminate = uop.valid && uop.is_cmps_second && uop.repne
		&& (zf || count_zero);

	// both branch kinds at once is a decode error
	always_comb
	begin
		if (uop.valid)
			a_branch_kind: assert (!(uop.is_jne && uop.is_jnbe))
				else $error("jne and jnbe both set on a valid uop");
	end

endmodule

`default_nettype wire

/* wb_stage.sv */
// --------------------------------------------------
// wb_stage
// writeback stage top, commits one uop per cycle
// --------------------------------------------------

`default_nettype none

module wb_stage (
	input  logic               clk,
	input  logic               rst,
	// decoded uop control
	input  logic               valid,
	input  logic               ld_eip,
	input  logic               ld_gpr1,
	input  logic               ld_gpr2,
	input  logic               ld_gpr3,
	input  logic               ld_seg,
	input  logic               ld_mm,
	input  logic               dcache_write,
	input  logic               ld_flags,
	input  logic               is_jne,
	input  logic               is_jnbe,
	input  logic               is_cmovc,
	input  logic               is_halt,
	input  logic               is_cmps_first,
	input  logic               is_cmps_second,
	input  logic               repne,
	input  wb_pkg::flag_mask_t flags_affected,
	// execute results
	input  wb_pkg::word_t      result_a,
	input  wb_pkg::word_t      result_c,
	input  wb_pkg::word_t      wb_flags_in,
	// operand and architectural state
	output wb_pkg::word_t      data1,
	output wb_pkg::word_t      current_flags,
	// commit enables
	output logic               v_ld_eip,
	output logic               v_ld_gpr1,
	output logic               v_ld_gpr2,
	output logic               v_ld_gpr3,
	output logic               v_ld_seg,
	output logic               v_ld_mm,
	output logic               v_dcache_write,
	output logic               v_ld_flags,
	output logic               halt,
	output logic               repne_terminate
);

	// --------------------------------------------------
	// uop bundle, straight from the ports
	// --------------------------------------------------
	wb_uop_if u_uop ();

	assign u_uop.valid          = valid;
	assign u_uop.ld_eip         = ld_eip;
	assign u_uop.ld_gpr1        = ld_gpr1;
	assign u_uop.ld_gpr2        = ld_gpr2;
	assign u_uop.ld_gpr3        = ld_gpr3;
	assign u_uop.ld_seg         = ld_seg;
	assign u_uop.ld_mm          = ld_mm;
	assign u_uop.dcache_write   = dcache_write;
	assign u_uop.ld_flags       = ld_flags;
	assign u_uop.is_jne         = is_jne;
	assign u_uop.is_jnbe        = is_jnbe;
	assign u_uop.is_cmovc       = is_cmovc;
	assign u_uop.is_halt        = is_halt;
	assign u_uop.is_cmps_first  = is_cmps_first;
	assign u_uop.is_cmps_second = is_cmps_second;
	assign u_uop.repne          = repne;
	assign u_uop.flags_affected = flags_affected;

	// validated flag load, shared by flags reg and port
	logic ld_flags_v;

	assign v_ld_flags = ld_flags_v;

	// --------------------------------------------------
	// blocks
	// --------------------------------------------------
	wb_commit_ctl u_commit_ctl (
		.uop             (u_uop.ctl),
		.current_flags   (current_flags),
		.result_c        (result_c),
		.v_ld_eip        (v_ld_eip),
		.v_ld_gpr1       (v_ld_gpr1),
		.v_ld_gpr2       (v_ld_gpr2),
		.v_ld_gpr3       (v_ld_gpr3),
		.v_ld_seg        (v_ld_seg),
		.v_ld_mm         (v_ld_mm),
		.v_dcache_write  (v_dcache_write),
		.ld_flags_v      (ld_flags_v),
		.halt            (halt),
		.repne_terminate (repne_terminate)
	);

	wb_flags u_flags (
		.clk           (clk),
		.rst           (rst),
		.uop           (u_uop.data),
		.ld_flags_v    (ld_flags_v),
		.wb_flags_in   (wb_flags_in),
		.current_flags (current_flags)
	);

	wb_cmps_select u_cmps_select (
		.clk      (clk),
		.rst      (rst),
		.uop      (u_uop.data),
		.result_a (result_a),
		.data1    (data1)
	);

endmodule

`default_nettype wire

/* tb_wb_stage.sv */
// --------------------------------------------------
// tb_wb_stage
// random self-checking testbench for the writeback
// stage, model of flags, cmps hold and enables
// --------------------------------------------------

`default_nettype none

module tb_wb_stage;
	timeunit 1ns;
	timeprecision 1ps;
	import wb_pkg::*;

	// --------------------------------------------------
	// DUT signals
	// --------------------------------------------------
	logic clk = 1'b0;
	logic rst;
	logic valid, ld_eip, ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm;
	logic dcache_write, ld_flags, is_jne, is_jnbe, is_cmovc;
	logic is_halt, is_cmps_first, is_cmps_second, repne;
	flag_mask_t flags_affected;
	word_t result_a, result_c, wb_flags_in;
	word_t data1, current_flags;
	logic v_ld_eip, v_ld_gpr1, v_ld_gpr2, v_ld_gpr3, v_ld_seg, v_ld_mm;
	logic v_dcache_write, v_ld_flags, halt, repne_terminate;

	// model state and bookkeeping
	word_t m_flags;
	word_t m_hold;
	logic m_have_first;
	logic [31:0] rng_state;
	int n_checks, n_errors, errs_start, cycles;
	int cnt_cond, cnt_flag_loads, cnt_pairs, cnt_repne_zf, cnt_repne_zero;

	wb_stage dut (.*);

	// 20 ns clock
	always #10 clk = ~clk;

	// hard stop for the whole run
	initial
	begin
		#200000;
		$display("timeout, simulation ran past its time limit");
		$display("*** TEST FAILED ***");
		$finish;
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// mask bit index to EFLAGS position
	function automatic int flag_position(input int bit_idx);
		case (bit_idx)
			0: return flag_pos_cf;
			1: return flag_pos_pf;
			2: return flag_pos_af;
			3: return flag_pos_zf;
			4: return flag_pos_sf;
			5: return flag_pos_df;
			default: return flag_pos_of;
		endcase
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("FAIL %s got %h exp %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("FAIL %s got %h exp %h at %0t", name, got, exp, $time);
		end
	endtask

	// modes: 0 plain, 1 cond, 2 flags, 3 cmps, 4 repne, 5 idle
	task automatic gen_uop(input int mode);
		logic [31:0] r1;
		logic [31:0] r4;
		r1 = next_rand();
		r4 = next_rand();
		valid = (mode == 0) ? r1[0] : (r1[2:0] != 3'd0);
		if (mode == 5)
			valid = 1'b0;
		ld_eip = r1[3];
		ld_gpr1 = r1[4];
		ld_gpr2 = r1[5];
		ld_gpr3 = r1[6];
		ld_seg = r1[7];
		ld_mm = r1[8];
		dcache_write = r1[9];
		ld_flags = (mode == 2) ? 1'b1 : r1[10];
		is_halt = r1[11] & r1[12];
		repne = (mode == 4) ? (r1[13] | r1[12]) : r1[13];
		// at most one branch kind
		is_jne = r1[14] & ~r1[15];
		is_jnbe = r1[15] & ~r1[14];
		is_cmovc = (mode == 1) ? r1[16] : (r1[16] & r1[17]);
		// at most one cmps half
		is_cmps_first = r1[18] & ~r1[19];
		is_cmps_second = r1[19] & (~r1[18] | (mode == 4));
		flags_affected = r1[26:20];
		result_a = (mode == 5) ? '0 : next_rand();
		wb_flags_in = next_rand();
		// zero count about one cycle in eight
		result_c = (r4[2:0] == 3'd0) ? '0 : r4;
	endtask

	// expected outputs from the model, before the edge
	task automatic check_cycle;
		logic cf;
		logic zf;
		logic exp_eip;
		logic exp_gpr1;
		cf = m_flags[flag_pos_cf];
		zf = m_flags[flag_pos_zf];
		if (is_jnbe)
			exp_eip = !cf && !zf;
		else if (is_jne)
			exp_eip = !zf;
		else
			exp_eip = ld_eip;
		exp_gpr1 = is_cmovc ? cf : ld_gpr1;
		check_word("current_flags", current_flags, m_flags);
		check_word("data1", data1, is_cmps_second ? m_hold : result_a);
		check_bit("v_ld_eip", v_ld_eip, valid && exp_eip);
		check_bit("v_ld_gpr1", v_ld_gpr1, valid && exp_gpr1);
		check_bit("v_ld_gpr2", v_ld_gpr2, valid && ld_gpr2);
		check_bit("v_ld_gpr3", v_ld_gpr3, valid && ld_gpr3);
		check_bit("v_ld_seg", v_ld_seg, valid && ld_seg);
		check_bit("v_ld_mm", v_ld_mm, valid && ld_mm);
		check_bit("v_dcache_write", v_dcache_write, valid && dcache_write);
		check_bit("v_ld_flags", v_ld_flags, valid && ld_flags);
		check_bit("halt", halt, valid && is_halt);
		check_bit("repne_terminate", repne_terminate,
			valid && is_cmps_second && repne && (zf || result_c == '0));
	endtask

	// state as it will be after the coming edge
	task automatic update_model;
		logic zf;
		int i;
		zf = m_flags[flag_pos_zf];
		if (valid && (is_jne || is_jnbe || is_cmovc))
			cnt_cond++;
		if (valid && is_cmps_second && m_have_first)
			cnt_pairs++;
		if (valid && is_cmps_second && repne && zf && result_c != '0)
			cnt_repne_zf++;
		if (valid && is_cmps_second && repne && !zf && result_c == '0)
			cnt_repne_zero++;
		if (valid && ld_flags)
		begin
			cnt_flag_loads++;
			for (i = 0; i < 7; i++)
				if (flags_affected[i])
					m_flags[flag_position(i)] = wb_flags_in[flag_position(i)];
		end
		if (valid && is_cmps_first)
		begin
			m_hold = result_a;
			m_have_first = 1'b1;
		end
	endtask

	// one uop: drive after the edge, check mid cycle
	task automatic step(input int mode);
		@(posedge clk);
		#2;
		gen_uop(mode);
		#10;
		check_cycle();
		update_model();
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, n_errors - errs_start);
		errs_start = n_errors;
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial
	begin
		rng_state = 32'h740a;
		n_checks = 0;
		n_errors = 0;
		errs_start = 0;
		cnt_cond = 0;
		cnt_flag_loads = 0;
		cnt_pairs = 0;
		cnt_repne_zf = 0;
		cnt_repne_zero = 0;
		m_flags = '0;
		m_hold = '0;
		m_have_first = 1'b0;
		rst = 1'b1;
		{valid, ld_eip, ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm} = '0;
		{dcache_write, ld_flags, is_jne, is_jnbe, is_cmovc} = '0;
		{is_halt, is_cmps_first, is_cmps_second, repne} = '0;
		flags_affected = '0;
		result_a = '0;
		result_c = '0;
		wb_flags_in = '0;

		// reset for 4 cycles
		for (cycles = 0; cycles < 4; cycles++)
			@(posedge clk);
		#2;
		rst = 1'b0;

		// 1: idle after reset
		for (cycles = 0; cycles < 8; cycles++)
		begin
			step(5);
			check_word("current_flags", current_flags, '0);
			check_word("data1", data1, '0);
		end
		end_test(1, "reset state");

		// 2: plain enables
		for (cycles = 0; cycles < 500; cycles++)
			step(0);
		end_test(2, "plain enables");

		// 3: conditional loads, counted within this test only
		cnt_cond = 0;
		for (cycles = 0; cycles < 300; cycles++)
			step(1);
		if (cnt_cond < 50)
		begin
			n_errors++;
			$display("test 3: too few conditional uops were generated");
		end
		end_test(3, "conditional loads");

		// 4: masked flag updates
		cnt_flag_loads = 0;
		for (cycles = 0; cycles < 300; cycles++)
			step(2);
		if (cnt_flag_loads < 100)
		begin
			n_errors++;
			$display("test 4: too few flag loads were generated");
		end
		end_test(4, "masked flags");

		// 5: cmps pairs, a fresh first uop is needed
		cnt_pairs = 0;
		m_have_first = 1'b0;
		cycles = 0;
		while (cnt_pairs < 20 && cycles < 2000)
		begin
			step(3);
			cycles++;
		end
		if (cnt_pairs < 20)
		begin
			n_errors++;
			$display("test 5: timed out before 20 cmps pairs completed");
		end
		end_test(5, "cmps pairs");

		// 6: halt and repne, both stop terms
		cnt_repne_zf = 0;
		cnt_repne_zero = 0;
		cycles = 0;
		while ((cnt_repne_zf < 5 || cnt_repne_zero < 5) && cycles < 2000)
		begin
			step(4);
			cycles++;
		end
		if (cnt_repne_zf < 5 || cnt_repne_zero < 5)
		begin
			n_errors++;
			$display("test 6: timed out before both repne stop terms were seen");
		end
		end_test(6, "halt and repne");

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
wb_pkg.sv
wb_uop_if.sv
wb_flags.sv
wb_cmps_select.sv
wb_commit_ctl.sv
wb_stage.sv
tb_wb_stage.sv

/* Makefile */
TOP := tb_wb_stage
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
